// File: fir_cfg.f
logic/fir_cfg_pkg.sv
logic/fir_addr_decode.sv
logic/fir_cfg_slave.sv
logic/fir_seq.sv
logic/fir_cfg_top.sv
dv/fir_cfg_checker.sv
dv/fir_cfg_tb.sv

// File: Makefile
# Verilator build and run of the FIR configuration testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fir_cfg_tb
FILELIST  := fir_cfg.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, the exit status comes from the search
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: dv/fir_cfg_tests.txt
# op addr wdata expected name
# ops are W write, R read and compare, P poll control until bit 2, S write attempt while busy
R 000 00000000 00000006 reset_ctrl
R 010 00000000 00000000 reset_tap
R 014 00000000 00000000 reset_samples
W 010 0000f40c 00000000 write_tap
R 010 00000000 0000000c read_tap
W 014 abcd8008 00000000 write_samples
R 014 00000000 00000008 read_samples
W 020 12345678 00000000 write_unmapped
R 020 00000000 00000000 read_unmapped
R 010 00000000 0000000c tap_after_unmapped
R 014 00000000 00000008 samples_after_unmapped
W 000 00000001 00000000 start_run
R 000 00000000 00000000 ctrl_busy
S 010 000003ff 00000000 stall_while_busy
P 000 00000000 00000006 poll_run_done
R 010 00000000 0000000c tap_kept_after_stall
R 000 00000000 00000006 ctrl_idle_after_run
W 010 00000123 00000000 mix_write_tap
R 010 00000000 00000123 mix_read_tap
W 014 fffffc05 00000000 mix_write_samples
R 014 00000000 00000005 mix_read_samples
W 010 000002aa 00000000 mix_rewrite_tap
R 014 00000000 00000005 mix_samples_kept
R 010 00000000 000002aa mix_read_tap_again
W 01c 0000ffff 00000000 mix_write_unmapped
R 01c 00000000 00000000 mix_read_unmapped
W 000 00000000 00000000 mix_ctrl_no_start
R 000 00000000 00000006 mix_ctrl_still_idle
W 014 00000000 00000000 zero_samples
W 010 00000004 00000000 zero_run_taps
W 000 00000001 00000000 zero_run_start
P 000 00000000 00000006 poll_zero_done
R 000 00000000 00000006 ctrl_idle_after_zero

// File: dv/fir_cfg_tb.sv
// Testbench top for the FIR configuration block, acts as AXI4-Lite master
// Run from the project root, test records come from dv/fir_cfg_tests.txt
module fir_cfg_tb import fir_cfg_pkg::*; ();

  localparam string TEST_FILE    = "dv/fir_cfg_tests.txt";
  localparam int    STALL_CYCLES = 16;

  logic  aclk;
  logic  aresetn;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  data_t rdata;
  logic  rvalid;
  logic  rready;
  addr_t awaddr;
  logic  awvalid;
  logic  awready;
  data_t wdata;
  logic  wvalid;
  logic  wready;
  logic  bvalid;
  logic  bready;

  // Test records, one entry per line of the file
  logic [7:0] op_q[$];
  addr_t      addr_q[$];
  data_t      wdata_q[$];
  data_t      exp_q[$];
  string      name_q[$];

  bit          loaded;
  bit          load_ok;
  int          limit_cycles;
  logic [31:0] lfsr_q = 32'he5efad3f;

  fir_cfg_top i_fir_cfg_top (
    .aclk    (aclk),
    .aresetn (aresetn),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready)
  );

  fir_cfg_checker i_fir_cfg_checker (
    .aclk    (aclk),
    .aresetn (aresetn),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .awready (awready)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  //////////////////////////////////////////////////////////////
  // Random back-pressure
  //////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic take_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // 0 to 3 cycles before rready or bready
  function automatic int pick_delay();
    logic [1:0] d;
    d[1] = take_bit();
    d[0] = take_bit();
    return int'(d);
  endfunction

  //////////////////////////////////////////////////////////////
  // Test file
  //////////////////////////////////////////////////////////////

  task automatic load_tests();
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    addr_t      a;
    data_t      w;
    data_t      e;
    string      nm;
    int         taps;
    int         smps;
    int         run_sum;
    taps    = 0;
    smps    = 0;
    run_sum = 0;
    fd      = $fopen(TEST_FILE, "r");
    load_ok = (fd != 0);
    if (load_ok) begin
      while ($fgets(line, fd) != 0) begin
        // Comment and blank lines stop the scan early
        n = $sscanf(line, "%c %h %h %h %s", op, a, w, e, nm);
        if (n == 5) begin
          op_q.push_back(op);
          addr_q.push_back(a);
          wdata_q.push_back(w);
          exp_q.push_back(e);
          name_q.push_back(nm);
          // Track the programmed sizes to size the watchdog
          if (op == "W" && a == ADDR_TAP) taps = int'(w[9:0]);
          if (op == "W" && a == ADDR_DATA) smps = int'(w[9:0]);
          if (op == "W" && a == ADDR_CTRL && w[0]) run_sum += taps * smps;
        end
      end
      $fclose(fd);
      limit_cycles = 200 * op_q.size() + run_sum;
      loaded = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////
  // AXI4-Lite master, every task starts and ends on a falling edge
  //////////////////////////////////////////////////////////////

  task automatic read_reg(input addr_t addr, output data_t data);
    int d;
    araddr  = addr;
    arvalid = 1'b1;
    // rvalid shows the address was taken on the last edge
    do begin
      @(negedge aclk);
    end while (!rvalid);
    arvalid = 1'b0;
    data    = rdata;
    d       = pick_delay();
    repeat (d) @(negedge aclk);
    rready = 1'b1;
    @(negedge aclk);
    rready = 1'b0;
  endtask

  task automatic write_reg(input addr_t addr, input data_t data);
    int d;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    do begin
      @(negedge aclk);
    end while (!wready);
    awvalid = 1'b0;
    // Data goes on the next edge, then the response
    do begin
      @(negedge aclk);
    end while (!bvalid);
    wvalid = 1'b0;
    d      = pick_delay();
    repeat (d) @(negedge aclk);
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
  endtask

  // Address offered for a fixed window, then withdrawn
  task automatic stall_write(input addr_t addr, input data_t data, input string name);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    i_fir_cfg_checker.start_stall();
    repeat (STALL_CYCLES) @(negedge aclk);
    awvalid = 1'b0;
    i_fir_cfg_checker.end_stall(name, STALL_CYCLES);
  endtask

  task automatic run_record(input int i);
    data_t v;
    case (op_q[i])
      "W": begin
        write_reg(addr_q[i], wdata_q[i]);
        i_fir_cfg_checker.log_done(name_q[i]);
      end
      "R": begin
        read_reg(addr_q[i], v);
        i_fir_cfg_checker.check_read(name_q[i], exp_q[i]);
      end
      "P": begin
        // Bit 2 is ap_idle
        do begin
          read_reg(addr_q[i], v);
        end while (!v[2]);
        i_fir_cfg_checker.check_read(name_q[i], exp_q[i]);
      end
      "S": stall_write(addr_q[i], wdata_q[i], name_q[i]);
      default: i_fir_cfg_checker.report_fault(name_q[i], "record has an unknown operation");
    endcase
  endtask

  //////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////

  initial begin
    aresetn = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    load_tests();
    if (!load_ok) begin
      $display("could not open the test file %s", TEST_FILE);
      $display("TEST FAIL");
      $finish;
    end else begin
      repeat (2) @(posedge aclk);
      @(negedge aclk);
      aresetn = 1'b1;
      @(negedge aclk);
      for (int i = 0; i < op_q.size(); i++) begin
        run_record(i);
      end
      i_fir_cfg_checker.report_counts();
      if (i_fir_cfg_checker.error_count() == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

  // 200 cycles per record plus every programmed run
  initial begin
    wait (loaded);
    repeat (limit_cycles) @(posedge aclk);
    $display("timeout: the tests did not finish within %0d cycles", limit_cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: dv/fir_cfg_checker.sv
// Response checker of the FIR configuration testbench
// Watches the read channels and awready on the DUT ports, compares when the stimulus asks
module fir_cfg_checker import fir_cfg_pkg::*; (
  input logic  aclk,
  input logic  aresetn,
  input logic  arvalid,
  input logic  arready,
  input logic  rvalid,
  input logic  rready,
  input data_t rdata,
  input logic  awready
);

  data_t rd_cap;
  logic  ar_hs_q;
  logic  rv_q;
  int    ar_bad;
  int    ar_bad_mark = 0;
  int    aw_high;
  int    aw_mark = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;

  //////////////////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////////////////

  // Data of the last read handshake
  always @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rd_cap <= '0;
    end else if (rvalid && rready) begin
      rd_cap <= rdata;
    end
  end

  // rvalid rises exactly one cycle after each read address handshake
  always @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ar_hs_q <= 1'b0;
      rv_q    <= 1'b0;
      ar_bad  <= 0;
    end else begin
      ar_hs_q <= arvalid && arready;
      rv_q    <= rvalid;
      if (ar_hs_q != (rvalid && !rv_q)) begin
        ar_bad <= ar_bad + 1;
      end
    end
  end

  // Running count of edges with awready high
  always @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      aw_high <= 0;
    end else if (awready) begin
      aw_high <= aw_high + 1;
    end
  end

  //////////////////////////////////////////////////////////////
  // Checks called by the stimulus
  //////////////////////////////////////////////////////////////

  task automatic check_read(input string name, input data_t exp);
    if (ar_bad != ar_bad_mark) begin
      fail_cnt++;
      ar_bad_mark = ar_bad;
      $display("%s: rvalid did not follow the read address handshake by one cycle", name);
    end else if (rd_cap === exp) begin
      pass_cnt++;
      $display("ok      %s read %h", name, rd_cap);
    end else begin
      fail_cnt++;
      $display("** Error %s: expected %h, actual %h", name, exp, rd_cap);
    end
  endtask

  // Writes have nothing to compare, only completion
  task automatic log_done(input string name);
    pass_cnt++;
    $display("ok      %s done", name);
  endtask

  task automatic start_stall();
    aw_mark = aw_high;
  endtask

  // Any awready edge inside the window is a failure
  task automatic end_stall(input string name, input int cycles);
    if (aw_high == aw_mark) begin
      pass_cnt++;
      $display("ok      %s awready low for %0d cycles", name, cycles);
    end else begin
      fail_cnt++;
      $display("%s: awready rose while the core was still busy", name);
    end
  endtask

  task automatic report_fault(input string name, input string what);
    fail_cnt++;
    $display("%s: %s", name, what);
  endtask

  task automatic report_counts();
    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
  endtask

  function automatic int error_count();
    return fail_cnt;
  endfunction

endmodule

// File: logic/fir_cfg_top.sv
// Top level of the FIR configuration block with its AXI4-Lite slave port
// Joins the address decoder, the register slave and the core sequencer
module fir_cfg_top import fir_cfg_pkg::*; (
  input  logic  aclk,
  input  logic  aresetn,
  // Read address channel
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  // Read data channel
  output data_t rdata,
  output logic  rvalid,
  input  logic  rready,
  // Write address channel
  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,
  // Write data channel
  input  data_t wdata,
  input  logic  wvalid,
  output logic  wready,
  // Write response channel
  output logic  bvalid,
  input  logic  bready
);

  cfg_req_t  req;
  logic      req_valid;
  logic      addr_accept;
  logic      aw_allow;
  core_cfg_t cfg;
  logic      done;

  ////////////////////////////////////////////////////////////
  // Address side
  ////////////////////////////////////////////////////////////

  fir_addr_decode i_fir_addr_decode (
    .araddr      (araddr),
    .arvalid     (arvalid),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .addr_accept (addr_accept),
    .aw_allow    (aw_allow),
    .arready     (arready),
    .awready     (awready),
    .req         (req),
    .req_valid   (req_valid)
  );

  ////////////////////////////////////////////////////////////
  // Registers and core
  ////////////////////////////////////////////////////////////

  fir_cfg_slave i_fir_cfg_slave (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .req         (req),
    .req_valid   (req_valid),
    .addr_accept (addr_accept),
    .aw_allow    (aw_allow),
    .rdata       (rdata),
    .rvalid      (rvalid),
    .rready      (rready),
    .wdata       (wdata),
    .wvalid      (wvalid),
    .wready      (wready),
    .bvalid      (bvalid),
    .bready      (bready),
    .done        (done),
    .cfg         (cfg)
  );

  fir_seq i_fir_seq (
    .aclk    (aclk),
    .aresetn (aresetn),
    .cfg     (cfg),
    .done    (done)
  );

endmodule

// File: logic/fir_seq.sv
// Stand-in for the FIR datapath, busy for tap count times sample count cycles
// Started by ap_start from the slave, answers with a one-cycle done pulse
module fir_seq import fir_cfg_pkg::*; (
  input  logic      aclk,
  input  logic      aresetn,
  input  core_cfg_t cfg,
  output logic      done
);

  seq_state_t state_q;

  // Sizes captured at start
  tap_num_t  tap_q;
  data_num_t smp_q;

  // Position inside the run
  tap_num_t  tap_cnt;
  data_num_t smp_cnt;

  logic last_tap;
  logic last_smp;

  assign last_tap = (tap_cnt == tap_q - tap_num_t'(1));
  assign last_smp = (smp_cnt == smp_q - data_num_t'(1));

  ////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q <= SEQ_IDLE;
      tap_cnt <= '0;
      smp_cnt <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          tap_cnt <= '0;
          smp_cnt <= '0;
          if (cfg.ap_start) begin
            // Empty filter finishes right away
            if (cfg.tap_num == '0 || cfg.data_num == '0) begin
              state_q <= SEQ_DONE;
            end else begin
              state_q <= SEQ_RUN;
            end
          end
        end
        SEQ_RUN: begin
          // One tap per cycle, samples step on the last tap
          if (last_tap) begin
            tap_cnt <= '0;
            smp_cnt <= smp_cnt + data_num_t'(1);
            if (last_smp) begin
              state_q <= SEQ_DONE;
            end
          end else begin
            tap_cnt <= tap_cnt + tap_num_t'(1);
          end
        end
        SEQ_DONE: state_q <= SEQ_IDLE;
        default:  state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Run sizes latched when the core starts
  always_ff @(posedge aclk) begin
    if (state_q == SEQ_IDLE && cfg.ap_start) begin
      tap_q <= cfg.tap_num;
      smp_q <= cfg.data_num;
    end
  end

  assign done = (state_q == SEQ_DONE);

  // Slave keeps writes out until done has been seen
  a_start_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    cfg.ap_start |-> state_q == SEQ_IDLE)
    else $error("ap_start while the sequencer is running");

endmodule

// File: logic/fir_cfg_slave.sv
// AXI4-Lite slave FSM and configuration registers of the FIR core
// Driven by the address decoder, feeds the programmed settings to the sequencer
module fir_cfg_slave import fir_cfg_pkg::*; (
  input  logic      aclk,
  input  logic      aresetn,
  // Decoded address request
  input  cfg_req_t  req,
  input  logic      req_valid,
  output logic      addr_accept,
  output logic      aw_allow,
  // Read data channel
  output data_t     rdata,
  output logic      rvalid,
  input  logic      rready,
  // Write data channel
  input  data_t     wdata,
  input  logic      wvalid,
  output logic      wready,
  // Write response channel
  output logic      bvalid,
  input  logic      bready,
  // Core side
  input  logic      done,
  output core_cfg_t cfg
);

  slave_state_t state_q;
  slave_state_t state_d;

  cfg_sel_t  sel_q;
  data_t     rdata_q;
  data_t     rdata_d;
  tap_num_t  tap_q;
  data_num_t data_q;

  logic ap_start;
  logic ap_done;
  logic ap_idle;

  logic rd_hs;
  logic wd_hs;
  logic b_hs;

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  assign rd_hs = rvalid && rready;
  assign wd_hs = wvalid && wready;
  assign b_hs  = bvalid && bready;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      SLV_IDLE: begin
        // req_valid only comes while addr_accept is high
        if (req_valid) begin
          state_d = req.is_read ? SLV_RDATA : SLV_WDATA;
        end
      end
      SLV_RDATA: begin
        if (rd_hs) begin
          state_d = SLV_IDLE;
        end
      end
      SLV_WDATA: begin
        if (wd_hs) begin
          state_d = SLV_BRESP;
        end
      end
      SLV_BRESP: begin
        if (b_hs) begin
          state_d = SLV_IDLE;
        end
      end
      default: state_d = SLV_IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q <= SLV_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Target register, held for the whole transaction
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      sel_q <= '0;
    end else if (rd_hs || b_hs) begin
      sel_q <= '0;
    end else if (req_valid) begin
      sel_q <= req.sel;
    end
  end

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  // Start is a single-cycle pulse after the data handshake
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ap_start <= 1'b0;
    end else begin
      ap_start <= wd_hs && sel_q.ctrl && wdata[0];
    end
  end

  // Done drops at start and comes back with the sequencer pulse
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ap_done <= 1'b1;
    end else if (ap_start) begin
      ap_done <= 1'b0;
    end else if (done) begin
      ap_done <= 1'b1;
    end
  end

  assign ap_idle = ap_start ? 1'b0 : ap_done;

  // Sizes take the low bits of the write data
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      tap_q  <= '0;
      data_q <= '0;
    end else if (wd_hs) begin
      if (sel_q.tap) begin
        tap_q <= wdata[$bits(tap_num_t)-1:0];
      end
      if (sel_q.data) begin
        data_q <= wdata[$bits(data_num_t)-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  // Unmapped addresses read as zero
  always_comb begin
    rdata_d = '0;
    if (req.sel.ctrl) begin
      rdata_d = data_t'({ap_idle, ap_done, ap_start});
    end else if (req.sel.tap) begin
      rdata_d = data_t'(tap_q);
    end else if (req.sel.data) begin
      rdata_d = data_t'(data_q);
    end
  end

  // Sampled at the address handshake so it stays put under back-pressure
  always_ff @(posedge aclk) begin
    if (req_valid && req.is_read) begin
      rdata_q <= rdata_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign addr_accept = (state_q == SLV_IDLE);
  assign aw_allow    = ap_idle;
  assign rdata       = rdata_q;
  assign rvalid      = (state_q == SLV_RDATA);
  assign wready      = (state_q == SLV_WDATA);
  assign bvalid      = (state_q == SLV_BRESP);

  assign cfg.ap_start = ap_start;
  assign cfg.tap_num  = tap_q;
  assign cfg.data_num = data_q;

  // Read data holds until the master takes it
  a_rdata_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before the handshake");

  // A write can only reach the data phase with the core idle
  a_wready_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    wready |-> ap_idle)
    else $error("wready high while the core is busy");

endmodule

// File: logic/fir_addr_decode.sv
// Address channel arbiter and register decoder for the FIR configuration slave
// Purely combinational, sits between the AXI address channels and the slave FSM
module fir_addr_decode import fir_cfg_pkg::*; (
  // Read address channel
  input  addr_t    araddr,
  input  logic     arvalid,
  // Write address channel
  input  addr_t    awaddr,
  input  logic     awvalid,
  // Flow control from the slave
  input  logic     addr_accept,
  input  logic     aw_allow,
  // Ready back to the master
  output logic     arready,
  output logic     awready,
  // Decoded request
  output cfg_req_t req,
  output logic     req_valid
);

  addr_t addr;

  ////////////////////////////////////////////////////////////
  // Arbitration and decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Reads win over writes in the same cycle
    arready = addr_accept && arvalid;
    // Writes also wait for an idle core
    awready = addr_accept && aw_allow && awvalid && !arvalid;

    // Address of the winning channel
    addr        = arvalid ? araddr : awaddr;
    req.is_read = arvalid;

    // Map lookup
    req.sel.ctrl = (addr == ADDR_CTRL);
    req.sel.tap  = (addr == ADDR_TAP);
    req.sel.data = (addr == ADDR_DATA);

    // One cycle per address handshake
    req_valid = (arvalid && arready) || (awvalid && awready);
  end

endmodule

// File: logic/fir_cfg_pkg.sv
// Shared widths, register map and types of the FIR configuration block
// Every RTL module of the block imports this package in its header
package fir_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // AXI4-Lite address and data
  typedef logic [11:0] addr_t;
  typedef logic [31:0] data_t;

  // Filter size settings
  typedef logic [9:0] tap_num_t;
  typedef logic [9:0] data_num_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam addr_t ADDR_CTRL = 12'h000;  // {ap_idle, ap_done, ap_start}
  localparam addr_t ADDR_TAP  = 12'h010;
  localparam addr_t ADDR_DATA = 12'h014;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Target register of one access, all zero when unmapped
  typedef struct packed {
    logic ctrl;
    logic tap;
    logic data;
  } cfg_sel_t;

  // Decoded request from the address channels
  typedef struct packed {
    logic     is_read;
    cfg_sel_t sel;
  } cfg_req_t;

  // Programmed settings toward the sequencer
  typedef struct packed {
    logic      ap_start;
    tap_num_t  tap_num;
    data_num_t data_num;
  } core_cfg_t;

  ////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////

  // Prefixes keep the two IDLE states apart in one scope
  typedef enum logic [1:0] {SLV_IDLE, SLV_RDATA, SLV_WDATA, SLV_BRESP} slave_state_t;
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_RUN, SEQ_DONE} seq_state_t;

endpackage
